//--- Bender.yml
package:
  name: axi4s_fifo

sources:
  # Packages first, then leaf modules, then the top level
  - design/axi4s_pkg.sv
  - design/fifo_pkg.sv
  - design/fifo_mem.sv
  - design/fifo_ptr_ctrl.sv
  - design/fifo_rd_fsm.sv
  - design/axi4s_fifo_core.sv
  - design/axi4s_fifo_mon.sv
  - design/axi4s_fifo_top.sv

  - target: test
    files:
      - testbench/tb_axi4s_fifo.sv

//--- design/axi4s_fifo_core.sv
// Word-based AXI4-Stream FIFO core

`timescale 1ns/1ps

module axi4s_fifo_core (
    input  logic                   aclk,
    input  logic                   rst_n,
    // Slave stream
    input  logic                   s_tvalid,
    output logic                   s_tready,
    input  axi4s_pkg::axi4s_word_t s_tword,
    // Master stream
    output logic                   m_tvalid,
    input  logic                   m_tready,
    output axi4s_pkg::axi4s_word_t m_tword,
    // Words held in total
    output fifo_pkg::level_t       fill_level
);

    // ----------------------------------------
    // Internal signals
    // ----------------------------------------
    logic                   wr_en;
    logic                   rd_en;
    logic                   load;
    logic                   consume;
    logic                   full;
    logic                   empty;
    logic                   out_word_busy;
    fifo_pkg::ptr_t         wr_ptr;
    fifo_pkg::ptr_t         rd_ptr;
    fifo_pkg::count_t       count;
    fifo_pkg::level_t       level_raw;
    axi4s_pkg::axi4s_word_t rd_word;

    // Stream handshakes
    assign s_tready = !full;
    assign wr_en    = s_tvalid && s_tready;
    assign consume  = m_tvalid && m_tready;

    // ----------------------------------------
    // FIFO blocks
    // ----------------------------------------
    fifo_mem u_mem (
        .aclk    (aclk),
        .wr_en   (wr_en),
        .wr_addr (wr_ptr),
        .wr_word (s_tword),
        .rd_en   (rd_en),
        .rd_addr (rd_ptr),
        .rd_word (rd_word)
    );

    fifo_ptr_ctrl u_ptr_ctrl (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .wr_en  (wr_en),
        .rd_en  (rd_en),
        .wr_ptr (wr_ptr),
        .rd_ptr (rd_ptr),
        .count  (count),
        .full   (full),
        .empty  (empty)
    );

    fifo_rd_fsm u_rd_fsm (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .empty     (empty),
        .consume   (consume),
        .rd_en     (rd_en),
        .load      (load),
        .out_valid (m_tvalid)
    );

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    // First word fall-through, stays put until reloaded
    always_ff @(posedge aclk) begin
        if (load) begin
            m_tword <= rd_word;
        end
    end

    // Held word or word in flight both count
    assign out_word_busy = m_tvalid || load;
    assign level_raw     = fifo_pkg::level_t'(count) + fifo_pkg::level_t'(out_word_busy);
    // Saturate at DEPTH when the output register is also full
    assign fill_level    = (level_raw > fifo_pkg::level_t'(fifo_pkg::DEPTH)) ?
                           fifo_pkg::level_t'(fifo_pkg::DEPTH) : level_raw;

    // Stalled beat must not change
    a_out_stable: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tword))
    );

endmodule : axi4s_fifo_core

//--- design/axi4s_fifo_mon.sv
// Output stream statistics monitor

`timescale 1ns/1ps

module axi4s_fifo_mon (
    input  logic                   aclk,
    input  logic                   rst_n,
    // Observed master stream
    input  logic                   m_tvalid,
    input  logic                   m_tready,
    input  axi4s_pkg::axi4s_word_t m_tword,
    // Running counts
    output fifo_pkg::stats_t       stats
);

    // ----------------------------------------
    // Beat decode
    // ----------------------------------------
    logic                           xfer;
    logic [fifo_pkg::BYTE_CNT_W-1:0] beat_bytes;

    assign xfer = m_tvalid && m_tready;

    // Valid bytes in this beat
    always_comb begin
        beat_bytes = '0;
        for (int i = 0; i < axi4s_pkg::BYTES; i++) begin
            beat_bytes = beat_bytes + fifo_pkg::BYTE_CNT_W'(m_tword.tkeep[i]);
        end
    end

    // ----------------------------------------
    // Counters
    // ----------------------------------------
    // All wrap at their width
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            stats <= '0;
        end else if (xfer) begin
            stats.word_cnt <= stats.word_cnt + 1'b1;
            // Packet ends on tlast
            if (m_tword.tlast) begin
                stats.pkt_cnt <= stats.pkt_cnt + 1'b1;
            end
            stats.byte_cnt <= stats.byte_cnt + beat_bytes;
        end
    end

endmodule : axi4s_fifo_mon

//--- design/axi4s_fifo_top.sv
// AXI4-Stream FIFO with output statistics

`timescale 1ns/1ps

module axi4s_fifo_top (
    input  logic                   aclk,
    input  logic                   rst_n,
    // Slave stream
    input  logic                   s_tvalid,
    output logic                   s_tready,
    input  axi4s_pkg::axi4s_word_t s_tword,
    // Master stream
    output logic                   m_tvalid,
    input  logic                   m_tready,
    output axi4s_pkg::axi4s_word_t m_tword,
    // Status
    output fifo_pkg::level_t       fill_level,
    output fifo_pkg::stats_t       stats
);

    // ----------------------------------------
    // FIFO
    // ----------------------------------------
    axi4s_fifo_core u_core (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .s_tword    (s_tword),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .m_tword    (m_tword),
        .fill_level (fill_level)
    );

    // Watches the master side only
    axi4s_fifo_mon u_mon (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tword  (m_tword),
        .stats    (stats)
    );

endmodule : axi4s_fifo_top

//--- design/axi4s_pkg.sv
// AXI4-Stream field definitions
// Stream word layout

package axi4s_pkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------
    // Bytes per beat
    localparam int BYTES   = 4;
    localparam int TDATA_W = BYTES * 8;
    localparam int TKEEP_W = BYTES;
    localparam int TID_W   = 4;
    localparam int TDEST_W = 4;
    localparam int TUSER_W = 8;

    // ----------------------------------------
    // Field types
    // ----------------------------------------
    typedef logic [TDATA_W-1:0] tdata_t;
    typedef logic [TKEEP_W-1:0] tkeep_t;
    typedef logic [TID_W-1:0]   tid_t;
    typedef logic [TDEST_W-1:0] tdest_t;
    typedef logic [TUSER_W-1:0] tuser_t;

    // One beat as stored in the FIFO, 53 bits
    typedef struct packed {
        tdata_t tdata;
        tkeep_t tkeep;
        logic   tlast;
        tid_t   tid;
        tdest_t tdest;
        tuser_t tuser;
    } axi4s_word_t;

endpackage : axi4s_pkg

//--- design/fifo_mem.sv
// FIFO storage array

`timescale 1ns/1ps

module fifo_mem (
    input  logic                   aclk,
    // Write port
    input  logic                   wr_en,
    input  fifo_pkg::ptr_t         wr_addr,
    input  axi4s_pkg::axi4s_word_t wr_word,
    // Read port
    input  logic                   rd_en,
    input  fifo_pkg::ptr_t         rd_addr,
    output axi4s_pkg::axi4s_word_t rd_word
);

    // ----------------------------------------
    // Array
    // ----------------------------------------
    axi4s_pkg::axi4s_word_t mem [fifo_pkg::DEPTH];

    // Write side
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // ----------------------------------------
    // Registered read
    // ----------------------------------------
    // Data valid the cycle after rd_en
    // Holds its value between reads
    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule : fifo_mem

//--- design/fifo_pkg.sv
// FIFO storage and status definitions

package fifo_pkg;

    // ----------------------------------------
    // Storage geometry
    // ----------------------------------------
    // Words in the storage array
    localparam int DEPTH   = 16;
    localparam int PTR_W   = $clog2(DEPTH);
    // One extra bit so a full array can be told from an empty one
    localparam int COUNT_W = PTR_W + 1;

    // Statistics counter widths
    localparam int WORD_CNT_W = 16;
    localparam int PKT_CNT_W  = 16;
    localparam int BYTE_CNT_W = 20;

    typedef logic [PTR_W-1:0]   ptr_t;
    typedef logic [COUNT_W-1:0] count_t;
    // Array plus output register, saturated at DEPTH
    typedef logic [COUNT_W-1:0] level_t;

    // Prefetch states
    typedef enum logic [1:0] {
        RD_IDLE  = 2'd0,
        RD_FETCH = 2'd1,
        RD_HOLD  = 2'd2
    } rd_state_e;

    // Output stream statistics, all wrapping
    typedef struct packed {
        logic [WORD_CNT_W-1:0] word_cnt;
        logic [PKT_CNT_W-1:0]  pkt_cnt;
        logic [BYTE_CNT_W-1:0] byte_cnt;
    } stats_t;

endpackage : fifo_pkg

//--- design/fifo_ptr_ctrl.sv
// FIFO pointers and occupancy

`timescale 1ns/1ps

module fifo_ptr_ctrl (
    input  logic             aclk,
    input  logic             rst_n,
    // Strobes from the core
    input  logic             wr_en,
    input  logic             rd_en,
    // Array addresses
    output fifo_pkg::ptr_t   wr_ptr,
    output fifo_pkg::ptr_t   rd_ptr,
    // Status
    output fifo_pkg::count_t count,
    output logic             full,
    output logic             empty
);

    // ----------------------------------------
    // Pointers
    // ----------------------------------------
    // Wrap modulo DEPTH
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= fifo_pkg::ptr_t'(wr_ptr + 1'b1);
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= fifo_pkg::ptr_t'(rd_ptr + 1'b1);
        end
    end

    // ----------------------------------------
    // Occupancy
    // ----------------------------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= fifo_pkg::count_t'(count + 1'b1);
                2'b01:   count <= fifo_pkg::count_t'(count - 1'b1);
                // Both or neither leaves the count alone
                default: count <= count;
            endcase
        end
    end

    // Flags from the registered count
    assign full  = (count == fifo_pkg::count_t'(fifo_pkg::DEPTH));
    assign empty = (count == '0);

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Core must gate writes with s_tready
    a_no_write_full: assert property (
        @(posedge aclk) disable iff (!rst_n)
        wr_en |-> !full
    );

    // Prefetch must never read an empty array
    a_no_read_empty: assert property (
        @(posedge aclk) disable iff (!rst_n)
        rd_en |-> !empty
    );

endmodule : fifo_ptr_ctrl

//--- design/fifo_rd_fsm.sv
// Output prefetch state machine

`timescale 1ns/1ps

module fifo_rd_fsm (
    input  logic aclk,
    input  logic rst_n,
    // Array status
    input  logic empty,
    // Output beat taken this cycle
    input  logic consume,
    // Array read strobe
    output logic rd_en,
    // Output register load the cycle after rd_en
    output logic load,
    // Output register holds a word
    output logic out_valid
);

    fifo_pkg::rd_state_e state;
    fifo_pkg::rd_state_e state_next;

    // ----------------------------------------
    // Read issue
    // ----------------------------------------
    // Fetch when the output register is free or being emptied
    always_comb begin
        rd_en = 1'b0;
        if (!empty) begin
            if (state == fifo_pkg::RD_IDLE) begin
                rd_en = 1'b1;
            end else if (state == fifo_pkg::RD_HOLD && consume) begin
                rd_en = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            fifo_pkg::RD_IDLE: begin
                if (rd_en) begin
                    state_next = fifo_pkg::RD_FETCH;
                end
            end
            // Read data lands in the output register at the end of this cycle
            fifo_pkg::RD_FETCH: begin
                state_next = fifo_pkg::RD_HOLD;
            end
            fifo_pkg::RD_HOLD: begin
                if (rd_en) begin
                    state_next = fifo_pkg::RD_FETCH;
                end else if (consume) begin
                    state_next = fifo_pkg::RD_IDLE;
                end
            end
            default: state_next = fifo_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state <= fifo_pkg::RD_IDLE;
            load  <= 1'b0;
        end else begin
            state <= state_next;
            // Read data valid one cycle after the strobe
            load  <= rd_en;
        end
    end

    assign out_valid = (state == fifo_pkg::RD_HOLD);

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Strobe, load and valid output in consecutive cycles
    // No second read while the first is still in flight
    a_load_after_read: assert property (
        @(posedge aclk) disable iff (!rst_n)
        rd_en |=> (load && !rd_en) ##1 out_valid
    );

endmodule : fifo_rd_fsm

//--- testbench/tb_axi4s_fifo.sv
// AXI4-Stream FIFO testbench
// Random source and sink against a queue model

`timescale 1ns/1ps

module tb_axi4s_fifo;

    // ----------------------------------------
    // Run lengths in clock cycles
    // ----------------------------------------
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYC    = 5;
    localparam int PH_MIX_CYC   = 300;
    localparam int PH_FILL_CYC  = 200;
    localparam int PH_EMPTY_CYC = 200;
    localparam int PH_LAST_CYC  = 200;
    localparam int BP_CYC       = 40;
    localparam int QUIET_CYC    = 8;
    localparam int DRAIN_CYC    = 64;
    localparam int TOTAL_CYC    = RESET_CYC + PH_MIX_CYC + PH_FILL_CYC + PH_EMPTY_CYC
                                + PH_LAST_CYC + BP_CYC + 4 * QUIET_CYC + 3 * DRAIN_CYC;
    localparam int WATCHDOG_CYC = TOTAL_CYC * 4 + 200;

    logic                   aclk;
    logic                   rst_n;
    logic                   s_tvalid;
    logic                   s_tready;
    axi4s_pkg::axi4s_word_t s_tword;
    logic                   m_tvalid;
    logic                   m_tready;
    axi4s_pkg::axi4s_word_t m_tword;
    fifo_pkg::level_t       fill_level;
    fifo_pkg::stats_t       stats;

    // Model state
    axi4s_pkg::axi4s_word_t          model_q[$];
    logic [fifo_pkg::WORD_CNT_W-1:0] model_words;
    logic [fifo_pkg::PKT_CNT_W-1:0]  model_pkts;
    logic [fifo_pkg::BYTE_CNT_W-1:0] model_bytes;
    int                              s_accepted;
    logic                            prev_stall;
    axi4s_pkg::axi4s_word_t          prev_word;
    logic [31:0]                     rng_state;
    int                              err_count;
    int                              check_count;
    int                              bp_start;

    axi4s_fifo_top dut_i (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .s_tword    (s_tword),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .m_tword    (m_tword),
        .fill_level (fill_level),
        .stats      (stats)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // Xorshift32 step
    function automatic logic [31:0] rand32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic chance(input int pct);
        return (rand32() % 100) < pct;
    endfunction

    function automatic axi4s_pkg::axi4s_word_t rand_word();
        axi4s_pkg::axi4s_word_t w;
        logic [31:0]            r;
        w.tdata = rand32();
        r       = rand32();
        w.tkeep = r[3:0];
        w.tlast = r[4];
        w.tid   = r[8:5];
        w.tdest = r[12:9];
        w.tuser = r[20:13];
        return w;
    endfunction

    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        err_count++;
        $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
    endtask

    task automatic report_error(input string msg);
        err_count++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    // Samples both handshakes at the edge and updates the model
    task automatic observe_edge();
        int ones;
        check_count++;
        if (prev_stall && !m_tvalid) begin
            report_error("m_tvalid dropped while the sink was stalling");
        end else if (prev_stall && m_tword !== prev_word) begin
            report_value("stability", prev_word, m_tword);
        end
        if (m_tvalid && m_tready) begin
            check_count++;
            if (model_q.size() == 0) begin
                report_error("master transfer while the model queue is empty");
            end else begin
                if (m_tword !== model_q[0]) begin
                    report_value("ordering", model_q[0], m_tword);
                end
                ones = 0;
                for (int i = 0; i < axi4s_pkg::BYTES; i++) begin
                    ones += model_q[0].tkeep[i];
                end
                model_words = model_words + 1'b1;
                model_pkts  = model_pkts + model_q[0].tlast;
                model_bytes = model_bytes + ones;
                void'(model_q.pop_front());
            end
        end
        if (s_tvalid && s_tready) begin
            model_q.push_back(s_tword);
            s_accepted++;
        end
        prev_stall = m_tvalid && !m_tready;
        prev_word  = m_tword;
    endtask

    // ----------------------------------------
    // Stimulus phases
    // ----------------------------------------
    // Source holds its word until accepted
    task automatic run_random(input int cycles, input int valid_pct, input int ready_pct);
        repeat (cycles) begin
            @(posedge aclk);
            observe_edge();
            if (!s_tvalid || s_tready) begin
                if (chance(valid_pct)) begin
                    s_tvalid <= 1'b1;
                    s_tword  <= rand_word();
                end else begin
                    s_tvalid <= 1'b0;
                end
            end
            m_tready <= chance(ready_pct);
        end
    endtask

    // No new beats, sink stalled
    task automatic run_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge aclk);
            observe_edge();
            if (s_tvalid && s_tready) begin
                s_tvalid <= 1'b0;
            end
            m_tready <= 1'b0;
        end
    endtask

    // Sink always ready until the model is empty
    task automatic run_drain();
        do begin
            @(posedge aclk);
            observe_edge();
            if (s_tvalid && s_tready) begin
                s_tvalid <= 1'b0;
            end
            m_tready <= 1'b1;
        end while (model_q.size() != 0 || s_tvalid);
    endtask

    task automatic check_fill();
        int exp_level;
        exp_level = (model_q.size() > fifo_pkg::DEPTH) ? fifo_pkg::DEPTH : model_q.size();
        check_count++;
        if (fill_level !== fifo_pkg::level_t'(exp_level)) begin
            report_value("fill_level", exp_level, fill_level);
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rng_state   = 32'h692c_8a7c;
        rst_n       = 1'b0;
        s_tvalid    = 1'b0;
        s_tword     = '0;
        m_tready    = 1'b0;
        model_words = '0;
        model_pkts  = '0;
        model_bytes = '0;
        s_accepted  = 0;
        prev_stall  = 1'b0;
        prev_word   = '0;
        err_count   = 0;
        check_count = 0;

        repeat (4) @(posedge aclk);
        rst_n <= 1'b1;
        @(posedge aclk);

        // Reset state before any input
        check_count++;
        if (m_tvalid !== 1'b0) report_value("reset m_tvalid", 0, m_tvalid);
        if (s_tready !== 1'b1) report_value("reset s_tready", 1, s_tready);
        if (fill_level !== '0) report_value("reset fill_level", 0, fill_level);
        if (stats !== '0) report_value("reset stats", 0, stats);
        observe_edge();

        // Mixed traffic, then fill-heavy and drain-heavy duty
        run_random(PH_MIX_CYC, 70, 70);
        run_random(PH_FILL_CYC, 90, 30);
        run_random(PH_EMPTY_CYC, 30, 90);
        run_quiet(QUIET_CYC);
        check_fill();
        run_drain();
        run_quiet(QUIET_CYC);
        check_fill();

        // Back-pressure from an empty FIFO
        bp_start = s_accepted;
        run_random(BP_CYC, 100, 0);
        check_count++;
        if (s_tready !== 1'b0) begin
            report_value("backpressure s_tready", 0, s_tready);
        end
        if (s_accepted - bp_start > fifo_pkg::DEPTH + 1) begin
            report_value("backpressure accepted", fifo_pkg::DEPTH + 1, s_accepted - bp_start);
        end
        run_quiet(QUIET_CYC);
        check_fill();

        // Release and finish
        run_random(PH_LAST_CYC, 60, 60);
        run_drain();
        run_quiet(QUIET_CYC);
        check_fill();

        check_count++;
        if (stats.word_cnt !== model_words) begin
            report_value("stats word_cnt", model_words, stats.word_cnt);
        end
        if (stats.pkt_cnt !== model_pkts) begin
            report_value("stats pkt_cnt", model_pkts, stats.pkt_cnt);
        end
        if (stats.byte_cnt !== model_bytes) begin
            report_value("stats byte_cnt", model_bytes, stats.byte_cnt);
        end

        $display("checks: %0d, errors: %0d, words delivered: %0d",
                 check_count, err_count, model_words);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Hang guard
    initial begin
        repeat (WATCHDOG_CYC) @(posedge aclk);
        $display("ERROR: run did not finish within %0d cycles, the FIFO or a phase hung",
                 WATCHDOG_CYC);
        $display("*** FAILED ***");
        $finish;
    end

endmodule : tb_axi4s_fifo

//--- vlog.f
design/axi4s_pkg.sv
design/fifo_pkg.sv
design/fifo_mem.sv
design/fifo_ptr_ctrl.sv
design/fifo_rd_fsm.sv
design/axi4s_fifo_core.sv
design/axi4s_fifo_mon.sv
design/axi4s_fifo_top.sv
testbench/tb_axi4s_fifo.sv
